// ==== verilog/binning_pkg.sv ====
package binning_pkg;

  // data and bus widths
  localparam int WEIGHT_W   = 32;
  localparam int BUS_ADDR_W = 32;
  localparam int BUS_DATA_W = 32;
  localparam int COUNT_W    = 9;    // per-bin counter, 9 bits like the bram counter arrays

  // default sizes handed to the top level
  localparam int DEF_NUM_BINS    = 16;
  localparam int DEF_BIN_CAP     = 8;
  localparam int DEF_MAX_WEIGHTS = 256;

  typedef logic [WEIGHT_W-1:0] weight_t;
  typedef logic [COUNT_W-1:0]  bin_count_t;

  typedef enum logic {
    REC_FULL  = 1'b0,   // bin hit the cap mid-run
    REC_FINAL = 1'b1    // leftover count after the last weight
  } rec_kind_e;

  //////////////////////////////
  // record word layout
  //////////////////////////////
  localparam int REC_KIND_BIT = 31;  // 1 = final
  localparam int REC_BIN_LSB  = 16;  // bin index in 23:16
  localparam int REC_CNT_LSB  = 0;   // count in 8:0

  // main sequencer
  typedef enum logic [1:0] {
    CTRL_IDLE, CTRL_RECEIVE, CTRL_COMPUTE, CTRL_FINISH
  } ctrl_state_e;

  // bin counter
  typedef enum logic [2:0] {
    CNT_IDLE, CNT_CLEAR, CNT_COUNT, CNT_FLUSH, CNT_SWEEP
  } cnt_state_e;

endpackage

// ==== verilog/bin_record_if.sv ====
`timescale 1ns/1ps

// bin records from the counter to the bus write master
interface bin_record_if #(
  parameter int  NUM_BINS = binning_pkg::DEF_NUM_BINS,
  localparam int BIN_W    = $clog2((NUM_BINS > 1) ? NUM_BINS : 2)
);

  logic                    valid;  // record on offer, held until taken
  logic                    ready;  // write master is idle
  binning_pkg::rec_kind_e  kind;
  logic [BIN_W-1:0]        bin;
  binning_pkg::bin_count_t count;
  logic                    last;   // last record of the final sweep

  modport src (output valid, kind, bin, count, last, input ready);
  modport dst (input valid, kind, bin, count, last, output ready);

endinterface

// ==== verilog/sdp_ram.sv ====
`timescale 1ns/1ps

// simple dual-port ram, one write port and one registered read port
module sdp_ram #(
  parameter type data_t = logic [31:0],
  parameter int  DEPTH  = 256,
  localparam int AW     = $clog2((DEPTH > 1) ? DEPTH : 2)
) (
  input  logic          Clk,
  input  logic          we,
  input  logic [AW-1:0] waddr,
  input  data_t         wdata,
  input  logic          re,
  input  logic [AW-1:0] raddr,
  output data_t         rdata
);

  data_t mem [DEPTH];

  always_ff @(posedge Clk) begin
    if (we)
      mem[waddr] <= wdata;
  end

  // read-first: same-cycle write to raddr is not seen, rdata holds while re low
  always_ff @(posedge Clk) begin
    if (re)
      rdata <= mem[raddr];
  end

endmodule

// ==== verilog/binning_ctrl.sv ====
`timescale 1ns/1ps

module binning_ctrl #(
  parameter int  MAX_WEIGHTS = binning_pkg::DEF_MAX_WEIGHTS,
  localparam int CNT_W       = $clog2(MAX_WEIGHTS + 1),
  localparam int AW          = $clog2((MAX_WEIGHTS > 1) ? MAX_WEIGHTS : 2)
) (
  input  logic                              Clk,
  input  logic                              rst_n,
  input  logic                              start,
  input  logic [CNT_W-1:0]                  weight_count,
  input  logic [binning_pkg::BUS_ADDR_W-1:0] out_base,
  input  logic                              s_valid,
  input  binning_pkg::weight_t              s_data,
  input  logic                              op_done,
  output logic                              busy,
  output logic                              done,
  output logic                              s_ready,
  output logic                              buf_we,
  output logic [AW-1:0]                     buf_waddr,
  output binning_pkg::weight_t              buf_wdata,
  output logic                              count_start,
  output logic [CNT_W-1:0]                  count_total,
  output logic [binning_pkg::BUS_ADDR_W-1:0] base_addr
);

  binning_pkg::ctrl_state_e state;

  logic [CNT_W-1:0] rx_cnt;      // words stored so far
  logic             take_start;
  logic             empty_op;    // start with zero weights, skip receive
  logic             accept;
  logic             rx_last;

  assign take_start = start && !busy;
  assign empty_op   = (weight_count == '0);
  assign accept     = s_valid && s_ready;
  assign rx_last    = accept && (rx_cnt == count_total - 1'b1);

  assign s_ready = (state == binning_pkg::CTRL_RECEIVE);
  assign busy    = (state == binning_pkg::CTRL_RECEIVE) || (state == binning_pkg::CTRL_COMPUTE);
  assign done    = (state == binning_pkg::CTRL_FINISH);   // one cycle, busy already low

  // stream words go straight into the weight buffer
  assign buf_we    = accept;
  assign buf_waddr = rx_cnt[AW-1:0];
  assign buf_wdata = s_data;

  //////////////////////////////
  // main sequencer
  //////////////////////////////
  always_ff @(posedge Clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= binning_pkg::CTRL_IDLE;
      rx_cnt      <= '0;
      count_start <= 1'b0;
    end else begin
      count_start <= rx_last || (take_start && empty_op);   // counter kicks off after receive
      case (state)
        binning_pkg::CTRL_IDLE, binning_pkg::CTRL_FINISH: begin
          if (take_start) begin
            state  <= empty_op ? binning_pkg::CTRL_COMPUTE : binning_pkg::CTRL_RECEIVE;
            rx_cnt <= '0;
          end else begin
            state <= binning_pkg::CTRL_IDLE;
          end
        end
        binning_pkg::CTRL_RECEIVE: begin
          if (accept) begin
            rx_cnt <= rx_cnt + 1'b1;
            if (rx_last)
              state <= binning_pkg::CTRL_COMPUTE;
          end
        end
        binning_pkg::CTRL_COMPUTE: begin
          if (op_done)                    // cmplt of the last final record
            state <= binning_pkg::CTRL_FINISH;
        end
        default: state <= binning_pkg::CTRL_IDLE;
      endcase
    end
  end

  // operation config, held for the whole run
  always_ff @(posedge Clk) begin
    if (take_start) begin
      count_total <= weight_count;
      base_addr   <= out_base;
    end
  end

endmodule

// ==== verilog/bin_counter.sv ====
`timescale 1ns/1ps

module bin_counter #(
  parameter int  NUM_BINS    = binning_pkg::DEF_NUM_BINS,
  parameter int  BIN_CAP     = binning_pkg::DEF_BIN_CAP,
  parameter int  MAX_WEIGHTS = binning_pkg::DEF_MAX_WEIGHTS,
  localparam int BIN_W       = $clog2((NUM_BINS > 1) ? NUM_BINS : 2),
  localparam int CNT_W       = $clog2(MAX_WEIGHTS + 1),
  localparam int AW          = $clog2((MAX_WEIGHTS > 1) ? MAX_WEIGHTS : 2)
) (
  input  logic                 Clk,
  input  logic                 rst_n,
  input  logic                 count_start,
  input  logic [CNT_W-1:0]     count_total,
  output logic                 buf_re,
  output logic [AW-1:0]        buf_raddr,
  input  binning_pkg::weight_t buf_rdata,
  bin_record_if.src            rec
);

  localparam logic [BIN_W-1:0]        LAST_BIN = BIN_W'(NUM_BINS - 1);
  localparam binning_pkg::bin_count_t CAP      = binning_pkg::bin_count_t'(BIN_CAP);

  binning_pkg::cnt_state_e state;

  logic [BIN_W-1:0]        bin_idx;    // clear and sweep pointer
  logic [CNT_W-1:0]        rd_idx;     // next weight to fetch
  logic                    s1_v;       // weight sits on buf_rdata
  logic                    s2_v;       // its count sits on cnt_rdata
  logic [BIN_W-1:0]        s1_bin;
  logic [BIN_W-1:0]        s2_bin;
  logic                    fwd;        // cnt_rdata is stale, use fwd_val
  binning_pkg::bin_count_t fwd_val;
  logic                    sw_rd;      // sweep read in flight
  binning_pkg::bin_count_t cur;
  binning_pkg::bin_count_t inc;
  logic                    s2_full;
  logic                    drained;

  logic                    cnt_we;
  logic                    cnt_re;
  logic [BIN_W-1:0]        cnt_waddr;
  logic [BIN_W-1:0]        cnt_raddr;
  binning_pkg::bin_count_t cnt_wdata;
  binning_pkg::bin_count_t cnt_rdata;

  sdp_ram #(
    .data_t (binning_pkg::bin_count_t),
    .DEPTH  (NUM_BINS)
  ) u_cnt_ram (
    .Clk   (Clk),
    .we    (cnt_we),
    .waddr (cnt_waddr),
    .wdata (cnt_wdata),
    .re    (cnt_re),
    .raddr (cnt_raddr),
    .rdata (cnt_rdata)
  );

  //////////////////////////////
  // count pipeline
  //////////////////////////////
  assign s1_bin  = buf_rdata[binning_pkg::WEIGHT_W-1 -: BIN_W];   // top bits pick the bin
  assign cur     = fwd ? fwd_val : cnt_rdata;
  assign inc     = cur + 1'b1;
  assign s2_full = (state == binning_pkg::CNT_COUNT) && s2_v && (inc == CAP);
  assign drained = !s1_v && !s2_v && (rd_idx == count_total);

  assign buf_re    = (state == binning_pkg::CNT_COUNT) && (rd_idx < count_total);
  assign buf_raddr = rd_idx[AW-1:0];

  always_comb begin
    cnt_we    = 1'b0;
    cnt_waddr = s2_bin;
    cnt_wdata = s2_full ? '0 : inc;     // a full bin restarts from zero
    cnt_re    = 1'b0;
    cnt_raddr = s1_bin;
    case (state)
      binning_pkg::CNT_CLEAR: begin
        cnt_we    = 1'b1;
        cnt_waddr = bin_idx;
        cnt_wdata = '0;
      end
      binning_pkg::CNT_COUNT: begin
        cnt_we = s2_v;                  // write-back of the older weight
        cnt_re = s1_v;                  // read for the newer one
      end
      binning_pkg::CNT_SWEEP: begin
        cnt_re    = !rec.valid && !sw_rd;
        cnt_raddr = bin_idx;
      end
      default: ;
    endcase
  end

  always_ff @(posedge Clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= binning_pkg::CNT_IDLE;
      bin_idx   <= '0;
      rd_idx    <= '0;
      s1_v      <= 1'b0;
      s2_v      <= 1'b0;
      fwd       <= 1'b0;
      sw_rd     <= 1'b0;
      rec.valid <= 1'b0;
    end else begin
      case (state)
        binning_pkg::CNT_IDLE: begin
          if (count_start) begin
            state   <= binning_pkg::CNT_CLEAR;
            bin_idx <= '0;
            rd_idx  <= '0;
            s1_v    <= 1'b0;
            s2_v    <= 1'b0;
            fwd     <= 1'b0;
          end
        end
        binning_pkg::CNT_CLEAR: begin
          bin_idx <= bin_idx + 1'b1;   // wraps to 0 on the last bin
          if (bin_idx == LAST_BIN)
            state <= binning_pkg::CNT_COUNT;
        end
        binning_pkg::CNT_COUNT: begin
          if (buf_re)
            rd_idx <= rd_idx + 1'b1;
          s1_v <= buf_re;
          s2_v <= s1_v;
          fwd  <= s1_v && s2_v && (s2_bin == s1_bin);   // same bin back to back
          if (s2_full) begin
            rec.valid <= 1'b1;
            state     <= binning_pkg::CNT_FLUSH;
          end else if (drained) begin
            state   <= binning_pkg::CNT_SWEEP;
            bin_idx <= '0;
            sw_rd   <= 1'b0;
          end
        end
        binning_pkg::CNT_FLUSH: begin
          if (rec.ready) begin          // pipeline frozen until the full record goes
            rec.valid <= 1'b0;
            state     <= binning_pkg::CNT_COUNT;
          end
        end
        binning_pkg::CNT_SWEEP: begin
          sw_rd <= cnt_re;
          if (sw_rd) begin
            rec.valid <= 1'b1;
          end else if (rec.valid && rec.ready) begin
            rec.valid <= 1'b0;
            bin_idx   <= bin_idx + 1'b1;
            if (rec.last)
              state <= binning_pkg::CNT_IDLE;
          end
        end
        default: state <= binning_pkg::CNT_IDLE;
      endcase
    end
  end

  // pipeline payload and record fields
  always_ff @(posedge Clk) begin
    if (state == binning_pkg::CNT_COUNT) begin
      s2_bin  <= s1_bin;
      fwd_val <= cnt_wdata;
    end
    if (s2_full) begin
      rec.kind  <= binning_pkg::REC_FULL;
      rec.bin   <= s2_bin;
      rec.count <= CAP;
      rec.last  <= 1'b0;
    end else if ((state == binning_pkg::CNT_SWEEP) && sw_rd) begin
      rec.kind  <= binning_pkg::REC_FINAL;
      rec.bin   <= bin_idx;
      rec.count <= cnt_rdata;
      rec.last  <= (bin_idx == LAST_BIN);
    end
  end

endmodule

// ==== verilog/bin_write_master.sv ====
`timescale 1ns/1ps

module bin_write_master #(
  parameter int  NUM_BINS = binning_pkg::DEF_NUM_BINS,
  localparam int BIN_W    = $clog2((NUM_BINS > 1) ? NUM_BINS : 2)
) (
  input  logic                               Clk,
  input  logic                               rst_n,
  input  logic [binning_pkg::BUS_ADDR_W-1:0] base_addr,
  bin_record_if.dst                          rec,
  input  logic                               cmdack,
  input  logic                               cmplt,
  output logic                               wr_req,
  output logic [binning_pkg::BUS_ADDR_W-1:0] wr_addr,
  output logic [binning_pkg::BUS_DATA_W-1:0] wr_data,
  output logic                               op_done
);

  logic                               active;    // a command is outstanding
  logic                               last_q;    // outstanding record closes the sweep
  logic                               take;
  logic                               cmd_end;
  logic [binning_pkg::BUS_ADDR_W-3:0] rec_idx;   // word offset from base
  logic [binning_pkg::BUS_DATA_W-1:0] rec_word;

  assign rec.ready = !active;
  assign take      = rec.valid && rec.ready;
  assign cmd_end   = active && !wr_req && cmplt;
  assign op_done   = cmd_end && last_q;

  // pack a record into one bus word
  always_comb begin
    rec_word = '0;
    rec_word[binning_pkg::REC_KIND_BIT] = (rec.kind == binning_pkg::REC_FINAL);
    rec_word[binning_pkg::REC_BIN_LSB +: BIN_W] = rec.bin;
    rec_word[binning_pkg::REC_CNT_LSB +: binning_pkg::COUNT_W] = rec.count;
  end

  //////////////////////////////
  // req / cmdack / cmplt
  //////////////////////////////
  always_ff @(posedge Clk or negedge rst_n) begin
    if (!rst_n) begin
      active  <= 1'b0;
      wr_req  <= 1'b0;
      rec_idx <= '0;
    end else begin
      if (take) begin
        active  <= 1'b1;
        wr_req  <= 1'b1;
        rec_idx <= rec.last ? '0 : rec_idx + 1'b1;   // next op starts at base again
      end else begin
        if (wr_req && cmdack)
          wr_req <= 1'b0;        // drop the cycle after ack
        if (cmd_end)
          active <= 1'b0;        // free for the next record
      end
    end
  end

  // address and data stay put until cmdack
  always_ff @(posedge Clk) begin
    if (take) begin
      wr_addr <= base_addr + {rec_idx, 2'b00};
      wr_data <= rec_word;
      last_q  <= rec.last;
    end
  end

endmodule

// ==== verilog/binning_top.sv ====
`timescale 1ns/1ps

module binning_top #(
  parameter int  NUM_BINS    = binning_pkg::DEF_NUM_BINS,
  parameter int  BIN_CAP     = binning_pkg::DEF_BIN_CAP,
  parameter int  MAX_WEIGHTS = binning_pkg::DEF_MAX_WEIGHTS,
  localparam int CNT_W       = $clog2(MAX_WEIGHTS + 1),
  localparam int AW          = $clog2((MAX_WEIGHTS > 1) ? MAX_WEIGHTS : 2)
) (
  input  logic                               Clk,
  input  logic                               rst_n,
  input  logic                               start,
  input  logic [CNT_W-1:0]                   weight_count,
  input  logic [binning_pkg::BUS_ADDR_W-1:0] out_base,
  input  logic                               s_valid,
  input  binning_pkg::weight_t               s_data,
  input  logic                               cmdack,
  input  logic                               cmplt,
  output logic                               busy,
  output logic                               done,
  output logic                               s_ready,
  output logic                               wr_req,
  output logic [binning_pkg::BUS_ADDR_W-1:0] wr_addr,
  output logic [binning_pkg::BUS_DATA_W-1:0] wr_data
);

  // weight buffer ports
  logic                 buf_we;
  logic [AW-1:0]        buf_waddr;
  binning_pkg::weight_t buf_wdata;
  logic                 buf_re;
  logic [AW-1:0]        buf_raddr;
  binning_pkg::weight_t buf_rdata;

  logic                               count_start;
  logic [CNT_W-1:0]                   count_total;
  logic [binning_pkg::BUS_ADDR_W-1:0] base_addr;
  logic                               op_done;

  bin_record_if #(.NUM_BINS(NUM_BINS)) rec_if ();

  binning_ctrl #(.MAX_WEIGHTS(MAX_WEIGHTS)) u_ctrl (
    .Clk, .rst_n, .start, .weight_count, .out_base, .s_valid, .s_data, .op_done,
    .busy, .done, .s_ready, .buf_we, .buf_waddr, .buf_wdata,
    .count_start, .count_total, .base_addr
  );

  sdp_ram #(.data_t(binning_pkg::weight_t), .DEPTH(MAX_WEIGHTS)) u_weight_buf (
    .Clk, .we(buf_we), .waddr(buf_waddr), .wdata(buf_wdata),
    .re(buf_re), .raddr(buf_raddr), .rdata(buf_rdata)
  );

  bin_counter #(
    .NUM_BINS(NUM_BINS), .BIN_CAP(BIN_CAP), .MAX_WEIGHTS(MAX_WEIGHTS)
  ) u_counter (
    .Clk, .rst_n, .count_start, .count_total,
    .buf_re, .buf_raddr, .buf_rdata, .rec(rec_if.src)
  );

  bin_write_master #(.NUM_BINS(NUM_BINS)) u_wr_master (
    .Clk, .rst_n, .base_addr, .rec(rec_if.dst),
    .cmdack, .cmplt, .wr_req, .wr_addr, .wr_data, .op_done
  );

endmodule

// ==== tb/binning_tests.svh ====
//////////////////////////////
// random source
//////////////////////////////
function automatic logic [31:0] galois_step(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
endfunction

// one lfsr step per bit
function automatic int unsigned take_bits(input int n);
  int unsigned v;
  v = 0;
  for (int i = 0; i < n; i++) begin
    lfsr = galois_step(lfsr);
    v    = (v << 1) | lfsr[0];
  end
  return v;
endfunction

// weight whose top bits select the given bin
function automatic logic [31:0] make_weight(input int bin, input logic [31:0] low);
  logic [31:0] mask;
  mask = 32'hffff_ffff >> BIN_W;
  return (32'(bin) << (32 - BIN_W)) | (low & mask);
endfunction

task automatic end_test(input string name, input int errs_before);
  tests_run++;
  if (errors == errs_before) begin
    $display("%-24s ok", name);
  end else begin
    tests_failed++;
    $display("%-24s failed, %0d errors", name, errors - errs_before);
  end
endtask

//////////////////////////////
// directed tests
//////////////////////////////
task automatic reset_values();
  int e0;
  e0 = errors;
  @(posedge Clk);
  if (s_ready !== 1'b0) report_mismatch("s_ready", s_ready, 1'b0);
  if (busy !== 1'b0)    report_mismatch("busy", busy, 1'b0);
  if (done !== 1'b0)    report_mismatch("done", done, 1'b0);
  if (wr_req !== 1'b0)  report_mismatch("wr_req", wr_req, 1'b0);
  end_test("reset", e0);
endtask

task automatic histogram_below_cap();
  int e0;
  e0 = errors;
  stim_q.delete();
  for (int i = 0; i < 12; i++)
    stim_q.push_back(make_weight((i * 5) % NUM_BINS, 32'(i) * 32'h0013_579b));  // distinct bins
  run_op(32'h0000_4000, 1'b0, 1'b0);
  end_test("histogram below cap", e0);
endtask

task automatic full_bin_flushes();
  int e0;
  int fulls;
  e0    = errors;
  fulls = 0;
  stim_q.delete();
  for (int i = 0; i < 20; i++)
    stim_q.push_back(make_weight(5, 32'(i) * 3));   // same bin back to back
  run_op(32'h0001_0000, 1'b0, 1'b0);
  foreach (log_data[i])
    if (log_data[i][31] == 1'b0)
      fulls++;
  if (fulls != 20 / BIN_CAP)
    report_mismatch("full records", fulls, 20 / BIN_CAP);
  end_test("full bin flushes", e0);
endtask

task automatic random_backpressure();
  int e0;
  e0 = errors;
  stim_q.delete();
  for (int i = 0; i < 200; i++)
    stim_q.push_back(32'(take_bits(32)));
  run_op(32'h0800_0100, 1'b1, 1'b0);   // stream gaps plus slow cmdack/cmplt
  end_test("random back-pressure", e0);
endtask

task automatic back_to_back_ops();
  int e0;
  e0 = errors;
  stim_q.delete();
  for (int i = 0; i < 10; i++)
    stim_q.push_back(make_weight((i < 7) ? 2 : 11, 32'(i)));
  run_op(32'h1000_0000, 1'b0, 1'b1);   // start poked while busy
  stim_q.delete();
  for (int i = 0; i < 6; i++)
    stim_q.push_back(make_weight(2, 32'(i) + 32'h40));
  run_op(32'h2000_0040, 1'b1, 1'b0);
  if (log_data.size() > 2 && log_data[2] !== 32'h8002_0006)   // 7 + 6 would have flushed
    report_mismatch("bin 2 after restart", log_data[2], 32'h8002_0006);
  end_test("back-to-back ops", e0);
endtask

// ==== tb/tb_binning.sv ====
`timescale 1ns/1ps

module tb_binning;

  localparam int NUM_BINS    = binning_pkg::DEF_NUM_BINS;
  localparam int BIN_CAP     = binning_pkg::DEF_BIN_CAP;
  localparam int MAX_WEIGHTS = binning_pkg::DEF_MAX_WEIGHTS;
  localparam int BIN_W       = $clog2(NUM_BINS);
  localparam int CNT_W       = $clog2(MAX_WEIGHTS + 1);
  localparam int CLK_PERIOD  = 10;
  localparam int MAX_DLY     = 3;                       // 2-bit responder delays
  localparam int TOTAL_W     = 12 + 20 + 200 + 10 + 6;  // weights over all tests
  localparam int TOTAL_REC   = 5 * NUM_BINS + TOTAL_W / BIN_CAP;
  localparam int WD_CYCLES   = TOTAL_W * 8 + TOTAL_REC * (2 * MAX_DLY + 8)
                               + 5 * (NUM_BINS + 30) + 100;

  logic                               Clk;
  logic                               rst_n;
  logic                               start;
  logic [CNT_W-1:0]                   weight_count;
  logic [binning_pkg::BUS_ADDR_W-1:0] out_base;
  logic                               s_valid;
  binning_pkg::weight_t               s_data;
  logic                               cmdack;
  logic                               cmplt;
  logic                               busy;
  logic                               done;
  logic                               s_ready;
  logic                               wr_req;
  logic [binning_pkg::BUS_ADDR_W-1:0] wr_addr;
  logic [binning_pkg::BUS_DATA_W-1:0] wr_data;

  logic [31:0] lfsr = 32'hab6d;  // shared by stimulus and responder, never drawn at once
  logic [31:0] stim_q[$];        // weights of the current op
  logic [31:0] exp_addr[$];
  logic [31:0] exp_data[$];
  logic [31:0] log_addr[$];      // writes seen by the responder
  logic [31:0] log_data[$];
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          done_cnt = 0;

  binning_top #(
    .NUM_BINS(NUM_BINS), .BIN_CAP(BIN_CAP), .MAX_WEIGHTS(MAX_WEIGHTS)
  ) i_dut (
    .Clk, .rst_n, .start, .weight_count, .out_base, .s_valid, .s_data,
    .cmdack, .cmplt, .busy, .done, .s_ready, .wr_req, .wr_addr, .wr_data
  );

  `include "binning_tests.svh"

  initial begin
    Clk = 1'b0;
    forever #(CLK_PERIOD / 2) Clk = ~Clk;
  end

  always @(posedge Clk)
    if (done === 1'b1)
      done_cnt <= done_cnt + 1;   // every done pulse, checked per op

  //////////////////////////////
  // bus responder
  //////////////////////////////
  initial begin : bus_responder
    int unsigned dly;
    cmdack = 1'b0;
    cmplt  = 1'b0;
    forever begin
      @(posedge Clk);
      if (wr_req === 1'b1) begin
        log_addr.push_back(wr_addr);      // addr and data held while wr_req
        log_data.push_back(wr_data);
        dly = take_bits(2);
        repeat (dly) @(posedge Clk);
        cmdack <= 1'b1;
        @(posedge Clk);
        cmdack <= 1'b0;                   // wr_req drops on this edge
        dly = take_bits(2);
        repeat (dly) @(posedge Clk);
        cmplt <= 1'b1;
        @(posedge Clk);
        cmplt <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // reference model
  //////////////////////////////
  function automatic void push_record(input logic [31:0] base, input int idx,
                                      input bit final_rec, input int bin, input int count);
    exp_addr.push_back(base + 32'(idx) * 4);
    exp_data.push_back((32'(final_rec) << 31) | (32'(bin) << 16) | 32'(count));
  endfunction

  function automatic void model_records(input logic [31:0] base);
    int cnt [NUM_BINS];
    int b;
    int k;
    exp_addr.delete();
    exp_data.delete();
    foreach (cnt[i])
      cnt[i] = 0;
    k = 0;
    foreach (stim_q[i]) begin
      b = int'(stim_q[i] >> (32 - BIN_W));   // top bits pick the bin
      cnt[b]++;
      if (cnt[b] == BIN_CAP) begin
        push_record(base, k, 1'b0, b, BIN_CAP);
        k++;
        cnt[b] = 0;
      end
    end
    for (b = 0; b < NUM_BINS; b++)           // final sweep, zeros included
      push_record(base, k + b, 1'b1, b, cnt[b]);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch at %0t ns: %s got 0x%h expected 0x%h", $time, name, got, exp);
    errors++;
  endtask

  task automatic check_records();
    int n;
    if (log_data.size() != exp_data.size())
      report_mismatch("record count", log_data.size(), exp_data.size());
    n = (log_data.size() < exp_data.size()) ? log_data.size() : exp_data.size();
    for (int i = 0; i < n; i++) begin
      if (log_addr[i] !== exp_addr[i])
        report_mismatch($sformatf("wr_addr[%0d]", i), log_addr[i], exp_addr[i]);
      if (log_data[i] !== exp_data[i])
        report_mismatch($sformatf("wr_data[%0d]", i), log_data[i], exp_data[i]);
    end
  endtask

  //////////////////////////////
  // one full operation
  //////////////////////////////
  task automatic run_op(input logic [31:0] base, input bit gaps, input bit poke_busy);
    int n;
    int acc;
    int dly;
    int done_before;
    n = stim_q.size();
    model_records(base);
    log_addr.delete();
    log_data.delete();
    done_before = done_cnt;
    @(posedge Clk);
    if (busy !== 1'b0)
      report_mismatch("busy", busy, 1'b0);
    start        <= 1'b1;
    weight_count <= CNT_W'(n);
    out_base     <= base;
    @(posedge Clk);
    start <= 1'b0;
    acc = 0;
    while (acc < n) begin
      if (gaps) begin
        dly = take_bits(2);        // idle cycles on the stream
        if (dly != 0) begin
          s_valid <= 1'b0;
          repeat (dly) @(posedge Clk);
        end
      end
      s_valid <= 1'b1;
      s_data  <= stim_q[acc];
      @(posedge Clk);
      while (s_ready !== 1'b1)
        @(posedge Clk);
      if (busy !== 1'b1)
        report_mismatch("busy", busy, 1'b1);
      acc++;
    end
    s_valid <= 1'b0;
    @(posedge Clk);
    if (s_ready !== 1'b0)          // receive closes right after the last word
      report_mismatch("s_ready", s_ready, 1'b0);
    if (poke_busy) begin
      start        <= 1'b1;        // must be ignored, engine is computing
      weight_count <= CNT_W'(1);
      out_base     <= 32'hdead_0000;
      @(posedge Clk);
      start <= 1'b0;
    end
    @(posedge Clk);
    while (done !== 1'b1)
      @(posedge Clk);
    if (busy !== 1'b0)
      report_mismatch("busy at done", busy, 1'b0);
    repeat (2) @(posedge Clk);
    if (done_cnt !== done_before + 1)
      report_mismatch("done pulses", done_cnt - done_before, 1);
    if (busy !== 1'b0)
      report_mismatch("busy after done", busy, 1'b0);
    check_records();
  endtask

  initial begin : watchdog
    #(WD_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the DUT stopped responding", WD_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : main
    rst_n        = 1'b0;
    start        = 1'b0;
    weight_count = '0;
    out_base     = '0;
    s_valid      = 1'b0;
    s_data       = '0;
    repeat (2) @(posedge Clk);
    rst_n <= 1'b1;
    reset_values();
    histogram_below_cap();
    full_bin_flushes();
    random_backpressure();
    back_to_back_ops();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+tb
verilog/binning_pkg.sv
verilog/bin_record_if.sv
verilog/sdp_ram.sv
verilog/binning_ctrl.sv
verilog/bin_counter.sv
verilog/bin_write_master.sv
verilog/binning_top.sv
tb/tb_binning.sv

// ==== Bender.yml ====
package:
  name: binning

sources:
  - files:
      - verilog/binning_pkg.sv
      - verilog/bin_record_if.sv
      - verilog/sdp_ram.sv
      - verilog/binning_ctrl.sv
      - verilog/bin_counter.sv
      - verilog/bin_write_master.sv
      - verilog/binning_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_binning.sv
